//--- hw/pw_engine_pkg.sv
package pw_engine_pkg;

    // ==========================================================
    // Widths and constants
    // ==========================================================

    // One lane slot in a memory word, top bit unused
    localparam int REG_SIZE       = 24;
    localparam int COEFF_WIDTH    = 23;
    localparam int LANES          = 4;
    localparam int MEM_ADDR_WIDTH = 15;
    localparam int MEM_DATA_WIDTH = LANES * REG_SIZE;

    // Depth of the lane pipe, operand capture to result
    localparam int ARITH_LATENCY  = 3;

    typedef logic [COEFF_WIDTH-1:0]    coeff_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [MEM_DATA_WIDTH-1:0] mem_word_t;

    localparam coeff_t MLDSA_Q = 23'd8380417;

    // ==========================================================
    // Enums and structs
    // ==========================================================

    typedef enum logic {
        RW_IDLE   = 1'b0,
        RW_ACTIVE = 1'b1
    } rw_cmd_t;

    typedef struct packed {
        rw_cmd_t   cmd;
        mem_addr_t addr;
    } mem_req_t;

    typedef enum logic [1:0] {
        PW_MUL = 2'd0,
        PW_ADD = 2'd1,
        PW_SUB = 2'd2
    } pw_mode_t;

    // Destination shares base_c with the accumulate source
    typedef struct packed {
        mem_addr_t base_a;
        mem_addr_t base_b;
        mem_addr_t base_c;
    } pw_base_addr_t;

    typedef struct packed {
        logic      valid;
        logic      last;
        mem_addr_t wr_addr;
    } pw_issue_t;

    typedef enum logic [1:0] {
        SEQ_IDLE  = 2'd0,
        SEQ_RUN   = 2'd1,
        SEQ_DRAIN = 2'd2
    } pw_seq_state_t;

endpackage

//--- hw/pw_mem_sequencer.sv
module pw_mem_sequencer #(
    parameter int POLY_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  pw_engine_pkg::pw_mode_t       mode_i,
    input  logic                          accumulate_i,
    input  pw_engine_pkg::pw_base_addr_t  base_addr_i,
    input  logic                          done_i,
    output pw_engine_pkg::mem_req_t       a_rd_req_o,
    output pw_engine_pkg::mem_req_t       b_rd_req_o,
    output pw_engine_pkg::mem_req_t       c_rd_req_o,
    output pw_engine_pkg::pw_issue_t      issue_o,
    output pw_engine_pkg::pw_mode_t       op_mode_o,
    output logic                          op_accumulate_o,
    output logic                          busy_o
);
    import pw_engine_pkg::*;

    localparam int CNT_W = $clog2(POLY_WORDS);

    pw_seq_state_t   state_q;
    logic [CNT_W-1:0] word_cnt_q;
    logic            last_word;
    mem_addr_t       word_ofs;

    // Run configuration held from start until done
    pw_mode_t        mode_q;
    logic            mac_q;
    pw_base_addr_t   base_q;

    assign last_word = (word_cnt_q == CNT_W'(POLY_WORDS - 1));
    assign word_ofs  = mem_addr_t'(word_cnt_q);

    // ==========================================================
    // Run state machine
    // ==========================================================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= SEQ_IDLE;
            word_cnt_q <= '0;
            mode_q     <= PW_MUL;
            mac_q      <= 1'b0;
            base_q     <= '0;
        end else begin
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i) begin
                        state_q    <= SEQ_RUN;
                        word_cnt_q <= '0;
                        mode_q     <= mode_i;
                        // Accumulate only has a meaning for multiply
                        mac_q      <= accumulate_i && (mode_i == PW_MUL);
                        base_q     <= base_addr_i;
                    end
                end
                SEQ_RUN: begin
                    word_cnt_q <= word_cnt_q + 1'b1;
                    if (last_word) begin
                        state_q <= SEQ_DRAIN;
                    end
                end
                SEQ_DRAIN: begin
                    // Wait for the last write to leave the aligner
                    if (done_i) begin
                        state_q <= SEQ_IDLE;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // One word issued per cycle while running
    always_comb begin
        a_rd_req_o.cmd   = (state_q == SEQ_RUN) ? RW_ACTIVE : RW_IDLE;
        a_rd_req_o.addr  = base_q.base_a + word_ofs;
        b_rd_req_o.cmd   = (state_q == SEQ_RUN) ? RW_ACTIVE : RW_IDLE;
        b_rd_req_o.addr  = base_q.base_b + word_ofs;
        c_rd_req_o.cmd   = (state_q == SEQ_RUN && mac_q) ? RW_ACTIVE : RW_IDLE;
        c_rd_req_o.addr  = base_q.base_c + word_ofs;

        issue_o.valid    = (state_q == SEQ_RUN);
        issue_o.last     = last_word;
        issue_o.wr_addr  = base_q.base_c + word_ofs;
    end

    assign op_mode_o       = mode_q;
    assign op_accumulate_o = mac_q;
    assign busy_o          = (state_q != SEQ_IDLE);

    // ==========================================================
    // Assertions
    // ==========================================================

    // A start that arrives mid-run does not restart the word count
    a_start_ignored_in_run: assert property (
        @(posedge clk) disable iff (!reset_n)
        (start_i && state_q == SEQ_RUN && !last_word)
            |=> (state_q == SEQ_RUN) && (word_cnt_q == $past(word_cnt_q) + 1'b1)
    );

    // C reads only for multiply-accumulate runs
    a_c_read_mac_only: assert property (
        @(posedge clk) disable iff (!reset_n)
        (c_rd_req_o.cmd == RW_ACTIVE)
            |-> (op_mode_o == PW_MUL) && op_accumulate_o
    );

endmodule

//--- hw/pw_lane_arith.sv
module pw_lane_arith (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       op_valid_i,
    input  pw_engine_pkg::pw_mode_t    op_mode_i,
    input  logic                       op_accumulate_i,
    input  pw_engine_pkg::mem_word_t   a_word_i,
    input  pw_engine_pkg::mem_word_t   b_word_i,
    input  pw_engine_pkg::mem_word_t   c_word_i,
    output logic                       res_valid_o,
    output pw_engine_pkg::mem_word_t   res_word_o
);
    import pw_engine_pkg::*;

    localparam int PROD_WIDTH = 2 * COEFF_WIDTH;

    typedef logic [PROD_WIDTH-1:0] prod_t;

    // Operation travels with each item down the pipe
    typedef struct packed {
        logic     valid;
        pw_mode_t mode;
        logic     accumulate;
    } pipe_ctrl_t;

    // Inputs below q give a result below q
    function automatic coeff_t mod_add(input coeff_t a, input coeff_t b);
        logic [COEFF_WIDTH:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, MLDSA_Q}) begin
            s = s - {1'b0, MLDSA_Q};
        end
        return s[COEFF_WIDTH-1:0];
    endfunction

    function automatic coeff_t mod_sub(input coeff_t a, input coeff_t b);
        coeff_t d;
        d = a - b;
        if (a < b) begin
            d = d + MLDSA_Q;
        end
        return d;
    endfunction

    // q = 2^23 - 2^13 + 1, so 2^23 folds to 2^13 - 1
    function automatic coeff_t reduce_prod(input prod_t x);
        logic [36:0] t1;
        logic [27:0] t2;
        logic [23:0] t3;
        t1 = 37'({x[45:23], 13'd0}) - 37'(x[45:23]) + 37'(x[22:0]);
        t2 = 28'({t1[36:23], 13'd0}) - 28'(t1[36:23]) + 28'(t1[22:0]);
        t3 = 24'({t2[27:23], 13'd0}) - 24'(t2[27:23]) + 24'(t2[22:0]);
        // Three folds leave less than 2q
        if (t3 >= {1'b0, MLDSA_Q}) begin
            t3 = t3 - {1'b0, MLDSA_Q};
        end
        return t3[COEFF_WIDTH-1:0];
    endfunction

    pipe_ctrl_t          s1_ctrl_q;
    pipe_ctrl_t          s2_ctrl_q;
    logic                s3_valid_q;
    prod_t  [LANES-1:0]  s1_val_d;
    prod_t  [LANES-1:0]  s1_val_q;
    coeff_t [LANES-1:0]  c_lane_d;
    coeff_t [LANES-1:0]  s1_c_q;
    coeff_t [LANES-1:0]  s2_val_d;
    coeff_t [LANES-1:0]  s2_val_q;
    coeff_t [LANES-1:0]  s2_c_q;
    coeff_t [LANES-1:0]  s3_val_d;
    coeff_t [LANES-1:0]  s3_val_q;
    logic                res_in_range;

    // ==========================================================
    // Stage 1: product, or corrected sum / difference
    // ==========================================================

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            c_lane_d[l] = c_word_i[l*REG_SIZE +: COEFF_WIDTH];
            case (op_mode_i)
                PW_MUL: s1_val_d[l] = prod_t'(a_word_i[l*REG_SIZE +: COEFF_WIDTH])
                                    * prod_t'(b_word_i[l*REG_SIZE +: COEFF_WIDTH]);
                PW_ADD: s1_val_d[l] = prod_t'(mod_add(a_word_i[l*REG_SIZE +: COEFF_WIDTH],
                                                      b_word_i[l*REG_SIZE +: COEFF_WIDTH]));
                PW_SUB: s1_val_d[l] = prod_t'(mod_sub(a_word_i[l*REG_SIZE +: COEFF_WIDTH],
                                                      b_word_i[l*REG_SIZE +: COEFF_WIDTH]));
                default: s1_val_d[l] = '0;
            endcase
        end
    end

    // ==========================================================
    // Stage 2: reduction, stage 3: accumulate
    // ==========================================================

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            if (s1_ctrl_q.mode == PW_MUL) begin
                s2_val_d[l] = reduce_prod(s1_val_q[l]);
            end else begin
                s2_val_d[l] = s1_val_q[l][COEFF_WIDTH-1:0];
            end

            if (s2_ctrl_q.mode == PW_MUL && s2_ctrl_q.accumulate) begin
                s3_val_d[l] = mod_add(s2_val_q[l], s2_c_q[l]);
            end else begin
                s3_val_d[l] = s2_val_q[l];
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_ctrl_q  <= '0;
            s2_ctrl_q  <= '0;
            s3_valid_q <= 1'b0;
        end else begin
            s1_ctrl_q  <= '{valid: op_valid_i, mode: op_mode_i, accumulate: op_accumulate_i};
            s2_ctrl_q  <= s1_ctrl_q;
            s3_valid_q <= s2_ctrl_q.valid;
        end
    end

    // Data stages only load on a valid item
    always_ff @(posedge clk) begin
        if (op_valid_i) begin
            s1_val_q <= s1_val_d;
            s1_c_q   <= c_lane_d;
        end
        if (s1_ctrl_q.valid) begin
            s2_val_q <= s2_val_d;
            s2_c_q   <= s1_c_q;
        end
        if (s2_ctrl_q.valid) begin
            s3_val_q <= s3_val_d;
        end
    end

    always_comb begin
        res_in_range = 1'b1;
        for (int l = 0; l < LANES; l++) begin
            res_word_o[l*REG_SIZE +: REG_SIZE] = {1'b0, s3_val_q[l]};
            if (s3_val_q[l] >= MLDSA_Q) begin
                res_in_range = 1'b0;
            end
        end
    end

    assign res_valid_o = s3_valid_q;

    // Whole pipe keeps every lane reduced, whatever the operation
    a_result_reduced: assert property (
        @(posedge clk) disable iff (!reset_n)
        res_valid_o |-> res_in_range
    );

endmodule

//--- hw/pw_write_aligner.sv
module pw_write_aligner (
    input  logic                       clk,
    input  logic                       reset_n,
    input  pw_engine_pkg::pw_issue_t   issue_i,
    input  logic                       res_valid_i,
    input  pw_engine_pkg::mem_word_t   res_word_i,
    output logic                       op_valid_o,
    output pw_engine_pkg::mem_req_t    wr_req_o,
    output pw_engine_pkg::mem_word_t   wr_data_o,
    output logic                       done_o
);
    import pw_engine_pkg::*;

    // Entry 0 lines up with read data, last entry with the pipe result
    pw_issue_t [ARITH_LATENCY:0] issue_pipe_q;
    pw_issue_t                   wr_tap;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_pipe_q <= '0;
        end else begin
            issue_pipe_q[0] <= issue_i;
            for (int i = 1; i <= ARITH_LATENCY; i++) begin
                issue_pipe_q[i] <= issue_pipe_q[i-1];
            end
        end
    end

    assign op_valid_o = issue_pipe_q[0].valid;
    assign wr_tap     = issue_pipe_q[ARITH_LATENCY];

    // ==========================================================
    // Write port
    // ==========================================================

    always_comb begin
        wr_req_o.cmd  = wr_tap.valid ? RW_ACTIVE : RW_IDLE;
        wr_req_o.addr = wr_tap.wr_addr;
        // Slot top bit is always written as zero
        for (int l = 0; l < LANES; l++) begin
            wr_data_o[l*REG_SIZE +: REG_SIZE] = {1'b0, res_word_i[l*REG_SIZE +: COEFF_WIDTH]};
        end
    end

    assign done_o = wr_tap.valid && wr_tap.last;

    // Issue delay must match read latency plus lane pipe depth
    a_result_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        wr_tap.valid |-> res_valid_i
    );

endmodule

//--- hw/pw_engine_top.sv
module pw_engine_top #(
    parameter int POLY_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  pw_engine_pkg::pw_mode_t       mode_i,
    input  logic                          accumulate_i,
    input  pw_engine_pkg::pw_base_addr_t  base_addr_i,
    output pw_engine_pkg::mem_req_t       a_rd_req_o,
    output pw_engine_pkg::mem_req_t       b_rd_req_o,
    output pw_engine_pkg::mem_req_t       c_rd_req_o,
    input  pw_engine_pkg::mem_word_t      a_rd_data_i,
    input  pw_engine_pkg::mem_word_t      b_rd_data_i,
    input  pw_engine_pkg::mem_word_t      c_rd_data_i,
    output pw_engine_pkg::mem_req_t       wr_req_o,
    output pw_engine_pkg::mem_word_t      wr_data_o,
    output logic                          busy_o,
    output logic                          done_o
);
    import pw_engine_pkg::*;

    // Sequencer to aligner and lane pipe
    pw_issue_t  issue;
    pw_mode_t   op_mode;
    logic       op_accumulate;

    // Aligner and lane pipe handshake
    logic       op_valid;
    logic       res_valid;
    mem_word_t  res_word;

    pw_mem_sequencer #(
        .POLY_WORDS (POLY_WORDS)
    ) u_sequencer (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start_i),
        .mode_i          (mode_i),
        .accumulate_i    (accumulate_i),
        .base_addr_i     (base_addr_i),
        .done_i          (done_o),
        .a_rd_req_o      (a_rd_req_o),
        .b_rd_req_o      (b_rd_req_o),
        .c_rd_req_o      (c_rd_req_o),
        .issue_o         (issue),
        .op_mode_o       (op_mode),
        .op_accumulate_o (op_accumulate),
        .busy_o          (busy_o)
    );

    pw_lane_arith u_lane_arith (
        .clk             (clk),
        .reset_n         (reset_n),
        .op_valid_i      (op_valid),
        .op_mode_i       (op_mode),
        .op_accumulate_i (op_accumulate),
        .a_word_i        (a_rd_data_i),
        .b_word_i        (b_rd_data_i),
        .c_word_i        (c_rd_data_i),
        .res_valid_o     (res_valid),
        .res_word_o      (res_word)
    );

    pw_write_aligner u_write_aligner (
        .clk         (clk),
        .reset_n     (reset_n),
        .issue_i     (issue),
        .res_valid_i (res_valid),
        .res_word_i  (res_word),
        .op_valid_o  (op_valid),
        .wr_req_o    (wr_req_o),
        .wr_data_o   (wr_data_o),
        .done_o      (done_o)
    );

endmodule

//--- tb/pw_engine_checker.sv
module pw_engine_checker #(
    parameter int POLY_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          start_i,
    input  pw_engine_pkg::pw_mode_t       mode_i,
    input  logic                          accumulate_i,
    input  pw_engine_pkg::pw_base_addr_t  base_addr_i,
    input  pw_engine_pkg::coeff_t         directed_exp_i,
    input  pw_engine_pkg::mem_req_t       a_rd_req_i,
    input  pw_engine_pkg::mem_req_t       b_rd_req_i,
    input  pw_engine_pkg::mem_req_t       c_rd_req_i,
    input  pw_engine_pkg::mem_req_t       wr_req_i,
    input  pw_engine_pkg::mem_word_t      wr_data_i,
    input  logic                          busy_i,
    input  logic                          done_i,
    output int                            error_count_o,
    output int                            runs_done_o,
    output int                            lanes_checked_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import pw_engine_pkg::*;

    // Configuration of the run in progress as captured when start is accepted
    pw_mode_t      run_mode;
    logic          run_mac;
    pw_base_addr_t run_base;
    coeff_t        run_exp;
    mem_word_t     c_snap [POLY_WORDS];
    logic          run_active = 1'b0;
    logic          busy_seen = 1'b0;
    logic          exp_busy = 1'b0;
    int            cycle = 0;
    int            run_start = 0;
    int            run_words = 0;
    int            run_errors = 0;
    int            error_count = 0;
    int            runs_done = 0;
    int            lanes_checked = 0;
    // Writes expected from earlier read requests
    int            due_cycle_q[$];
    int            due_ofs_q[$];

    assign error_count_o   = error_count;
    assign runs_done_o     = runs_done;
    assign lanes_checked_o = lanes_checked;

    // Reference rule for one lane
    function automatic coeff_t ref_lane(input pw_mode_t mode, input logic mac,
                                        input coeff_t a, input coeff_t b, input coeff_t c);
        longint unsigned q;
        longint unsigned r;
        q = MLDSA_Q;
        case (mode)
            PW_MUL: begin
                r = (longint'(a) * longint'(b)) % q;
                if (mac) begin
                    r = (r + c) % q;
                end
            end
            PW_ADD:  r = (longint'(a) + b) % q;
            default: r = (longint'(a) + q - b) % q;
        endcase
        return coeff_t'(r);
    endfunction

    function automatic string mode_text(input pw_mode_t mode, input logic mac);
        case (mode)
            PW_MUL:  return mac ? "multiply-accumulate" : "multiply";
            PW_ADD:  return "add";
            default: return "subtract";
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        error_count++;
        run_errors++;
    endtask

    // ==========================================================
    // Run start, sampled where the DUT samples it
    // ==========================================================

    always @(posedge clk) begin
        if (reset_n && start_i && !busy_seen) begin
            run_mode   = mode_i;
            run_mac    = accumulate_i && (mode_i == PW_MUL);
            run_base   = base_addr_i;
            run_exp    = directed_exp_i;
            run_start  = cycle;
            run_words  = 0;
            run_errors = 0;
            run_active = 1'b1;
            exp_busy   = 1'b1;
            for (int i = 0; i < POLY_WORDS; i++) begin
                c_snap[i] = pw_engine_tb.c_mem[mem_addr_t'(base_addr_i.base_c + i)];
            end
        end
    end

    // ==========================================================
    // Read, write and status checks mid-cycle
    // ==========================================================

    always @(negedge clk) begin
        logic      issuing;
        logic      write_due;
        logic      last_due;
        int        ofs;
        int        step;
        mem_word_t a_word;
        mem_word_t b_word;
        coeff_t    want;
        coeff_t    got;
        if (reset_n) begin
            if (busy_i !== exp_busy) begin
                report_mismatch($sformatf("busy_o is %b, expected %b", busy_i, exp_busy));
            end

            // Word i is read in the i-th cycle after start
            step    = cycle - run_start;
            issuing = run_active && (step < POLY_WORDS);
            if ((a_rd_req_i.cmd == RW_ACTIVE) != issuing) begin
                report_mismatch($sformatf("A read strobe is %0d, expected %0d",
                                          a_rd_req_i.cmd, issuing));
            end else if (issuing) begin
                if (a_rd_req_i.addr !== mem_addr_t'(run_base.base_a + step) ||
                    b_rd_req_i.cmd != RW_ACTIVE ||
                    b_rd_req_i.addr !== mem_addr_t'(run_base.base_b + step)) begin
                    report_mismatch($sformatf("word %0d: A or B read request wrong", step));
                end
                if (run_mac && (c_rd_req_i.cmd != RW_ACTIVE ||
                    c_rd_req_i.addr !== mem_addr_t'(run_base.base_c + step))) begin
                    report_mismatch($sformatf("word %0d: C read request wrong", step));
                end
                due_cycle_q.push_back(cycle + 4);
                due_ofs_q.push_back(step);
            end
            if (!issuing && b_rd_req_i.cmd == RW_ACTIVE) begin
                report_mismatch("B read request outside the issue window");
            end
            if (!run_mac && c_rd_req_i.cmd == RW_ACTIVE) begin
                report_mismatch("C read request without accumulate");
            end else if (!issuing && c_rd_req_i.cmd == RW_ACTIVE) begin
                report_mismatch("C read request outside the issue window");
            end

            // Writes land exactly four cycles after the read
            write_due = (due_cycle_q.size() > 0) && (due_cycle_q[0] == cycle);
            last_due  = write_due && (due_ofs_q[0] == POLY_WORDS - 1);
            if ((wr_req_i.cmd == RW_ACTIVE) != write_due) begin
                report_mismatch($sformatf("write strobe is %0d, expected %0d",
                                          wr_req_i.cmd, write_due));
            end
            if (done_i !== last_due) begin
                report_mismatch($sformatf("done_o is %b, expected %b", done_i, last_due));
            end
            if (write_due) begin
                ofs = due_ofs_q.pop_front();
                void'(due_cycle_q.pop_front());
                if (wr_req_i.cmd == RW_ACTIVE) begin
                    run_words++;
                    if (wr_req_i.addr !== mem_addr_t'(run_base.base_c + ofs)) begin
                        report_mismatch($sformatf("word %0d written to address %h",
                                                  ofs, wr_req_i.addr));
                    end
                    a_word = pw_engine_tb.a_mem[mem_addr_t'(run_base.base_a + ofs)];
                    b_word = pw_engine_tb.b_mem[mem_addr_t'(run_base.base_b + ofs)];
                    for (int l = 0; l < LANES; l++) begin
                        want = ref_lane(run_mode, run_mac,
                                        a_word[l*REG_SIZE +: COEFF_WIDTH],
                                        b_word[l*REG_SIZE +: COEFF_WIDTH],
                                        c_snap[ofs][l*REG_SIZE +: COEFF_WIDTH]);
                        got  = wr_data_i[l*REG_SIZE +: COEFF_WIDTH];
                        lanes_checked++;
                        if (got !== want || wr_data_i[l*REG_SIZE+COEFF_WIDTH] !== 1'b0) begin
                            report_mismatch($sformatf("word %0d lane %0d: got %0d, expected %0d",
                                                      ofs, l, got, want));
                        end
                    end
                    if (ofs == 0 && wr_data_i[COEFF_WIDTH-1:0] !== run_exp) begin
                        report_mismatch($sformatf("directed lane 0: got %0d, trace has %0d",
                                                  wr_data_i[COEFF_WIDTH-1:0], run_exp));
                    end
                end
            end

            if (done_i && run_active) begin
                if (run_words != POLY_WORDS) begin
                    report_mismatch($sformatf("%0d words written, expected %0d",
                                              run_words, POLY_WORDS));
                end
                $display("Test %0d: %s, %0d words, %0d mismatches, %s", runs_done + 1,
                         mode_text(run_mode, run_mac), run_words, run_errors,
                         (run_errors == 0) ? "pass" : "fail");
                runs_done++;
                run_active = 1'b0;
                exp_busy   = 1'b0;
            end
        end
        busy_seen = busy_i;
        cycle++;
    end

endmodule

//--- tb/pw_engine_tb.sv
module pw_engine_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pw_engine_pkg::*;

    localparam int POLY_WORDS = 64;
    localparam int MEM_DEPTH  = 2 ** MEM_ADDR_WIDTH;

    // One line of the trace file
    typedef struct packed {
        pw_mode_t      mode;
        logic          accumulate;
        pw_base_addr_t base;
        coeff_t        a0;
        coeff_t        b0;
        coeff_t        c0;
        coeff_t        exp_res;
    } trace_entry_t;

    logic          clk;
    logic          reset_n;
    logic          start;
    pw_mode_t      mode;
    logic          accumulate;
    pw_base_addr_t base_addr;
    coeff_t        directed_exp;
    mem_req_t      a_rd_req;
    mem_req_t      b_rd_req;
    mem_req_t      c_rd_req;
    mem_req_t      wr_req;
    mem_word_t     a_rd_data;
    mem_word_t     b_rd_data;
    mem_word_t     c_rd_data;
    mem_word_t     wr_data;
    logic          busy;
    logic          done;
    int            error_count;
    int            runs_done;
    int            lanes_checked;

    mem_word_t     a_mem [MEM_DEPTH];
    mem_word_t     b_mem [MEM_DEPTH];
    mem_word_t     c_mem [MEM_DEPTH];
    mem_req_t      a_pend = '0;
    mem_req_t      b_pend = '0;
    mem_req_t      c_pend = '0;

    trace_entry_t  tests[$];
    int            cycle_count = 0;
    int            cycle_limit = 0;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    pw_engine_top #(
        .POLY_WORDS (POLY_WORDS)
    ) dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .start_i      (start),
        .mode_i       (mode),
        .accumulate_i (accumulate),
        .base_addr_i  (base_addr),
        .a_rd_req_o   (a_rd_req),
        .b_rd_req_o   (b_rd_req),
        .c_rd_req_o   (c_rd_req),
        .a_rd_data_i  (a_rd_data),
        .b_rd_data_i  (b_rd_data),
        .c_rd_data_i  (c_rd_data),
        .wr_req_o     (wr_req),
        .wr_data_o    (wr_data),
        .busy_o       (busy),
        .done_o       (done)
    );

    pw_engine_checker #(
        .POLY_WORDS (POLY_WORDS)
    ) u_checker (
        .clk             (clk),
        .reset_n         (reset_n),
        .start_i         (start),
        .mode_i          (mode),
        .accumulate_i    (accumulate),
        .base_addr_i     (base_addr),
        .directed_exp_i  (directed_exp),
        .a_rd_req_i      (a_rd_req),
        .b_rd_req_i      (b_rd_req),
        .c_rd_req_i      (c_rd_req),
        .wr_req_i        (wr_req),
        .wr_data_i       (wr_data),
        .busy_i          (busy),
        .done_i          (done),
        .error_count_o   (error_count),
        .runs_done_o     (runs_done),
        .lanes_checked_o (lanes_checked)
    );

    // ==========================================================
    // Memory models with data one cycle after the request
    // ==========================================================

    always @(negedge clk) begin
        if (a_pend.cmd == RW_ACTIVE) a_rd_data <= a_mem[a_pend.addr];
        if (b_pend.cmd == RW_ACTIVE) b_rd_data <= b_mem[b_pend.addr];
        if (c_pend.cmd == RW_ACTIVE) c_rd_data <= c_mem[c_pend.addr];
        a_pend <= a_rd_req;
        b_pend <= b_rd_req;
        c_pend <= c_rd_req;
        if (wr_req.cmd == RW_ACTIVE) begin
            c_mem[wr_req.addr] <= wr_data;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic mem_word_t random_word();
        mem_word_t w;
        w = '0;
        for (int l = 0; l < LANES; l++) begin
            w[l*REG_SIZE +: COEFF_WIDTH] = coeff_t'($urandom % MLDSA_Q);
            // Slot top bit is random and ignored by the DUT
            w[l*REG_SIZE + COEFF_WIDTH]  = 1'($urandom);
        end
        return w;
    endfunction

    task automatic read_trace(output logic ok);
        int               fd;
        int               f [9];
        logic [8*160-1:0] line_buf;
        trace_entry_t     e;
        ok = 1'b0;
        fd = $fopen("tb/pw_trace.txt", "r");
        if (fd != 0) begin
            line_buf = '0;
            while ($fgets(line_buf, fd) != 0) begin
                // Comment lines do not parse and are skipped
                if ($sscanf(line_buf, "%d %d %h %h %h %d %d %d %d", f[0], f[1], f[2], f[3],
                            f[4], f[5], f[6], f[7], f[8]) == 9) begin
                    e.mode        = pw_mode_t'(f[0][1:0]);
                    e.accumulate  = f[1][0];
                    e.base.base_a = mem_addr_t'(f[2]);
                    e.base.base_b = mem_addr_t'(f[3]);
                    e.base.base_c = mem_addr_t'(f[4]);
                    e.a0          = coeff_t'(f[5]);
                    e.b0          = coeff_t'(f[6]);
                    e.c0          = coeff_t'(f[7]);
                    e.exp_res     = coeff_t'(f[8]);
                    tests.push_back(e);
                end
                line_buf = '0;
            end
            $fclose(fd);
            ok = (tests.size() > 0);
        end
    endtask

    // Random operands with the directed lane 0 of word 0 on top
    task automatic load_operands(input trace_entry_t e);
        for (int i = 0; i < POLY_WORDS; i++) begin
            a_mem[mem_addr_t'(e.base.base_a + i)] = random_word();
            b_mem[mem_addr_t'(e.base.base_b + i)] = random_word();
            c_mem[mem_addr_t'(e.base.base_c + i)] = random_word();
        end
        a_mem[e.base.base_a][COEFF_WIDTH-1:0] = e.a0;
        b_mem[e.base.base_b][COEFF_WIDTH-1:0] = e.b0;
        c_mem[e.base.base_c][COEFF_WIDTH-1:0] = e.c0;
    endtask

    task automatic run_test(input trace_entry_t e);
        load_operands(e);
        mode         = e.mode;
        accumulate   = e.accumulate;
        base_addr    = e.base;
        directed_exp = e.exp_res;
        start        = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // Mid-run start with other settings that must be ignored
        repeat (POLY_WORDS / 2) @(negedge clk);
        mode       = PW_ADD;
        accumulate = 1'b1;
        base_addr  = '{base_a: 15'h7000, base_b: 15'h7100, base_c: 15'h7200};
        start      = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // Returns on the first idle cycle so the next start follows at once
        while (busy) @(negedge clk);
    endtask

    initial begin
        logic trace_ok;
        reset_n      = 1'b0;
        start        = 1'b0;
        mode         = PW_MUL;
        accumulate   = 1'b0;
        base_addr    = '0;
        directed_exp = '0;
        a_rd_data    = '0;
        b_rd_data    = '0;
        c_rd_data    = '0;
        void'($urandom(32'h3c05));
        read_trace(trace_ok);
        if (!trace_ok) begin
            $display("Could not read any test from tb/pw_trace.txt, run stopped");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            cycle_limit = tests.size() * (POLY_WORDS + 20);
            repeat (3) @(posedge clk);
            @(negedge clk);
            reset_n = 1'b1;
            @(negedge clk);
            foreach (tests[i]) begin
                run_test(tests[i]);
            end
            repeat (4) @(negedge clk);
            $display("%0d of %0d tests run, %0d lanes checked, %0d mismatches",
                     runs_done, tests.size(), lanes_checked, error_count);
            if (error_count == 0 && runs_done == tests.size()) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

//--- pw_engine.f
hw/pw_engine_pkg.sv
hw/pw_mem_sequencer.sv
hw/pw_lane_arith.sv
hw/pw_write_aligner.sv
hw/pw_engine_top.sv
tb/pw_engine_checker.sv
tb/pw_engine_tb.sv

//--- tb/pw_trace.txt
# mode (0 mul, 1 add, 2 sub)  acc  base_a base_b base_c (hex)
# a0 b0 c0 are lane 0 of word 0, last column is the expected written lane 0 (decimal)
1 0 0000 0100 0200 8380416 1       0       0
2 0 0040 0140 0240 0       1       0       8380416
0 0 0080 0180 0280 8380416 8380416 0       1
0 1 00c0 01c0 02c0 8380416 8380416 8380416 0
1 0 1000 2000 3000 12345   67890   0       80235
2 0 1040 2040 3040 100     8380416 0       101
0 0 1080 2080 3080 2       4190209 0       1
0 0 10c0 20c0 30c0 0       5       0       0
0 1 4000 5000 6000 3       1000    8380000 2583
0 0 4040 5040 6040 4096    4096    0       16382
1 1 4080 5080 6080 5       6       1234    11
2 0 40c0 50c0 60c0 8380416 0       0       8380416
0 0 0000 0000 7fc0 1       8380416 0       8380416
0 1 0100 0100 0100 65536   65536   0       4193792
1 0 0200 0300 0400 4190208 4190209 0       0
2 0 0500 0600 0700 1       2       0       8380416
0 1 0800 0900 0a00 8380416 1       1       0
0 0 0b00 0c00 0d00 8192    1024    0       8191
0 1 0e00 0f00 1f00 8192    1024    8372226 0
1 0 7fc0 7fc0 0000 0       0       0       0
